// ==== Makefile ====
TOP = tb_exec_unit

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f exec_unit.f --top-module $(TOP) -o V$(TOP)

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== exec_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_alu (
    input  exec_pkg::opcode_t  cmd_op,
    input  exec_pkg::word_t    cmd_a,
    input  exec_pkg::word_t    cmd_b,
    input  exec_pkg::word_t    cmd_target,
    input  exec_pkg::imm_t     cmd_value,
    input  wire                cmd_high,
    input  wire                f1,
    input  wire                f2,
    output exec_pkg::word_t    res_data,
    output logic               res_cond,
    output logic               res_jump,
    output exec_pkg::word_t    res_addr
);
    import exec_pkg::*;

    logic                  is_sub;
    word_t                 b_in;
    word_t                 sum;
    shamt_t                amount;
    logic                  over_shift;
    logic [word_width-1:0] shl_res;
    logic [word_width-1:0] shr_res;
    word_t                 load_res;

    // one adder for add and sub
    assign is_sub = (cmd_op == op_sub);
    assign b_in   = cmd_b ^ {word_width{is_sub}};
    assign sum    = cmd_a + b_in + word_t'(is_sub);  // carry in completes two's complement

    assign amount     = cmd_b[$bits(shamt_t)-1:0];
    assign over_shift = |cmd_b[word_width-1:$bits(shamt_t)];

    // shift the inverted word so vacated bits come back as ones
    always_comb
    begin
        if (over_shift)
        begin
            shl_res = '1;
            shr_res = '1;
        end
        else
        begin
            shl_res = ~((~cmd_a) << amount);
            shr_res = ~((~cmd_a) >> amount);
        end
    end

    assign load_res = cmd_high ? {cmd_value, cmd_a[31:0]}
                               : {cmd_a[63:32], cmd_value};

    always_comb
    begin
        case (cmd_op)
            op_add, op_sub:
                res_data = sum;
            op_shl:
                res_data = shl_res;
            op_shr:
                res_data = shr_res;
            op_pass, op_call, op_ret:
                res_data = cmd_a;
            op_load:
                res_data = load_res;
            default:
                res_data = '0;  // compares, flag ops, jumps
        endcase
    end

    always_comb
    begin
        case (cmd_op)
            op_eq:
                res_cond = (cmd_a == cmd_b);
            op_lt:
                res_cond = (cmd_a < cmd_b);     // unsigned
            op_gt:
                res_cond = (cmd_a > cmd_b);
            op_nf1:
                res_cond = !f1;
            op_f1f2:
                res_cond = f1 && f2;
            op_f1:
                res_cond = f1;
            default:
                res_cond = 1'b0;
        endcase
    end

    assign res_jump = (cmd_op == op_jmp) || ((cmd_op == op_bf1) && f1);
    assign res_addr = res_jump ? cmd_target : '0;

endmodule

`default_nettype wire

// ==== exec_cmd_in.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_cmd_in (
    input  wire                clock,
    input  wire                arst_n,
    input  wire                in_req,
    output logic               in_ack,
    input  exec_pkg::opcode_t  in_op,
    input  exec_pkg::word_t    in_a,
    input  exec_pkg::word_t    in_b,
    input  exec_pkg::word_t    in_target,
    input  exec_pkg::imm_t     in_value,
    input  wire                in_high,
    input  wire                cmd_take,
    output logic               cmd_full,
    output exec_pkg::opcode_t  cmd_op,
    output exec_pkg::word_t    cmd_a,
    output exec_pkg::word_t    cmd_b,
    output exec_pkg::word_t    cmd_target,
    output exec_pkg::imm_t     cmd_value,
    output logic               cmd_high
);
    import exec_pkg::*;

    hs_state_t state;
    logic      capture;

    // ack low and slot free
    assign capture = (state == idle) && in_req && !cmd_full;
    assign in_ack  = (state == ack_high);

    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state    <= idle;
            cmd_full <= 1'b0;
        end
        else
        begin
            case (state)
                idle:
                begin
                    if (capture)
                        state <= ack_high;
                end
                ack_high:
                begin
                    if (!in_req)
                        state <= idle;  // producer released req
                end
                default:
                    state <= idle;
            endcase

            if (capture)
                cmd_full <= 1'b1;
            else if (cmd_take)
                cmd_full <= 1'b0;   // result side took it
        end
    end

    always_ff @(posedge clock)
    begin
        if (capture)
        begin
            cmd_op     <= in_op;
            cmd_a      <= in_a;
            cmd_b      <= in_b;
            cmd_target <= in_target;
            cmd_value  <= in_value;
            cmd_high   <= in_high;
        end
    end

endmodule

`default_nettype wire

// ==== exec_flags.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_flags (
    input  wire                clock,
    input  wire                arst_n,
    input  wire                cmd_take,
    input  exec_pkg::opcode_t  cmd_op,
    input  wire                res_cond,
    output logic               f1,
    output logic               f2
);
    import exec_pkg::*;

    logic is_compare;
    logic update;

    always_comb
    begin
        case (cmd_op)
            op_eq, op_lt, op_gt:
                is_compare = 1'b1;
            default:
                is_compare = 1'b0;
        endcase
    end

    // only on the commit edge
    assign update = cmd_take && is_compare;

    // f1 is the newest compare, f2 the one before
    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            f1 <= 1'b0;
            f2 <= 1'b0;
        end
        else if (update)
        begin
            f2 <= f1;
            f1 <= res_cond;
        end
    end

endmodule

`default_nettype wire

// ==== exec_pkg.sv ====
`default_nettype none

package exec_pkg;

    localparam int word_width = 64;

    typedef logic [word_width-1:0]         word_t;
    typedef logic [31:0]                   imm_t;
    typedef logic [$clog2(word_width)-1:0] shamt_t;  // in-range shift amount
    typedef logic [5:0]                    opcode_t;

    localparam opcode_t op_add  = 6'd0;
    localparam opcode_t op_sub  = 6'd1;
    localparam opcode_t op_shl  = 6'd2;
    localparam opcode_t op_shr  = 6'd3;
    localparam opcode_t op_pass = 6'd4;
    localparam opcode_t op_load = 6'd5;
    localparam opcode_t op_call = 6'd6;   // passes a, no jump
    localparam opcode_t op_ret  = 6'd7;   // passes a, no jump
    localparam opcode_t op_eq   = 6'd8;
    localparam opcode_t op_lt   = 6'd9;
    localparam opcode_t op_gt   = 6'd10;
    localparam opcode_t op_nf1  = 6'd11;
    localparam opcode_t op_f1f2 = 6'd12;
    localparam opcode_t op_f1   = 6'd13;
    localparam opcode_t op_jmp  = 6'd14;
    localparam opcode_t op_bf1  = 6'd15;

    // shared by the receive and send sides
    typedef enum logic [1:0]
    {
        idle,
        ack_high,
        wait_low
    } hs_state_t;

endpackage

`default_nettype wire

// ==== exec_result_out.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_result_out (
    input  wire              clock,
    input  wire              arst_n,
    input  wire              cmd_full,
    output logic             cmd_take,
    input  exec_pkg::word_t  res_data,
    input  wire              res_cond,
    input  wire              res_jump,
    input  exec_pkg::word_t  res_addr,
    output logic             out_req,
    input  wire              out_ack,
    output exec_pkg::word_t  out_data,
    output logic             out_cond,
    output logic             out_jump,
    output exec_pkg::word_t  out_addr
);
    import exec_pkg::*;

    hs_state_t state;

    // register counts as empty only in idle
    assign cmd_take = cmd_full && (state == idle);
    assign out_req  = (state == ack_high);

    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state    <= idle;
            out_jump <= 1'b0;
        end
        else
        begin
            case (state)
                idle:
                begin
                    if (cmd_take)
                        state <= ack_high;
                end
                ack_high:
                begin
                    if (out_ack)
                        state <= wait_low;  // drop req
                end
                wait_low:
                begin
                    if (!out_ack)
                        state <= idle;
                end
                default:
                    state <= idle;
            endcase

            if (cmd_take)
                out_jump <= res_jump;
        end
    end

    always_ff @(posedge clock)
    begin
        if (cmd_take)
        begin
            out_data <= res_data;
            out_cond <= res_cond;
            out_addr <= res_addr;
        end
    end

endmodule

`default_nettype wire

// ==== exec_unit.f ====
exec_pkg.sv
exec_cmd_in.sv
exec_flags.sv
exec_alu.sv
exec_result_out.sv
exec_unit.sv
tb_exec_unit.sv

// ==== exec_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
    input  wire                clock,
    input  wire                arst_n,
    input  wire                in_req,
    output logic               in_ack,
    input  exec_pkg::opcode_t  in_op,
    input  exec_pkg::word_t    in_a,
    input  exec_pkg::word_t    in_b,
    input  exec_pkg::word_t    in_target,
    input  exec_pkg::imm_t     in_value,
    input  wire                in_high,
    output logic               out_req,
    input  wire                out_ack,
    output exec_pkg::word_t    out_data,
    output logic               out_cond,
    output logic               out_jump,
    output exec_pkg::word_t    out_addr
);
    import exec_pkg::*;

    logic    cmd_full;
    logic    cmd_take;
    opcode_t cmd_op;
    word_t   cmd_a;
    word_t   cmd_b;
    word_t   cmd_target;
    imm_t    cmd_value;
    logic    cmd_high;
    logic    f1;
    logic    f2;
    word_t   res_data;
    logic    res_cond;
    logic    res_jump;
    word_t   res_addr;

    exec_cmd_in u_cmd_in (
        .clock      (clock),
        .arst_n     (arst_n),
        .in_req     (in_req),
        .in_ack     (in_ack),
        .in_op      (in_op),
        .in_a       (in_a),
        .in_b       (in_b),
        .in_target  (in_target),
        .in_value   (in_value),
        .in_high    (in_high),
        .cmd_take   (cmd_take),
        .cmd_full   (cmd_full),
        .cmd_op     (cmd_op),
        .cmd_a      (cmd_a),
        .cmd_b      (cmd_b),
        .cmd_target (cmd_target),
        .cmd_value  (cmd_value),
        .cmd_high   (cmd_high)
    );

    exec_alu u_alu (
        .cmd_op     (cmd_op),
        .cmd_a      (cmd_a),
        .cmd_b      (cmd_b),
        .cmd_target (cmd_target),
        .cmd_value  (cmd_value),
        .cmd_high   (cmd_high),
        .f1         (f1),
        .f2         (f2),
        .res_data   (res_data),
        .res_cond   (res_cond),
        .res_jump   (res_jump),
        .res_addr   (res_addr)
    );

    exec_flags u_flags (
        .clock    (clock),
        .arst_n   (arst_n),
        .cmd_take (cmd_take),
        .cmd_op   (cmd_op),
        .res_cond (res_cond),
        .f1       (f1),
        .f2       (f2)
    );

    exec_result_out u_result_out (
        .clock    (clock),
        .arst_n   (arst_n),
        .cmd_full (cmd_full),
        .cmd_take (cmd_take),
        .res_data (res_data),
        .res_cond (res_cond),
        .res_jump (res_jump),
        .res_addr (res_addr),
        .out_req  (out_req),
        .out_ack  (out_ack),
        .out_data (out_data),
        .out_cond (out_cond),
        .out_jump (out_jump),
        .out_addr (out_addr)
    );

endmodule

`default_nettype wire

// ==== tb_exec_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_exec_unit;
    import exec_pkg::*;

    localparam int num_cmds = 238;  // 24 arith, 142 shift, 72 compare and jump
    localparam int clk_half = 50;

    logic         clock;
    logic         arst_n;
    logic         in_req;
    logic         in_ack;
    opcode_t      in_op;
    word_t        in_a;
    word_t        in_b;
    word_t        in_target;
    imm_t         in_value;
    logic         in_high;
    logic         out_req;
    logic         out_ack;
    word_t        out_data;
    logic         out_cond;
    logic         out_jump;
    word_t        out_addr;
    logic [15:0]  lfsr;
    logic         m_f1;  // model flags
    logic         m_f2;
    logic [129:0] exp_q[$];  // {data, cond, jump, addr}
    int           sent;
    int           received;

    exec_unit DUT (
        .clock     (clock),
        .arst_n    (arst_n),
        .in_req    (in_req),
        .in_ack    (in_ack),
        .in_op     (in_op),
        .in_a      (in_a),
        .in_b      (in_b),
        .in_target (in_target),
        .in_value  (in_value),
        .in_high   (in_high),
        .out_req   (out_req),
        .out_ack   (out_ack),
        .out_data  (out_data),
        .out_cond  (out_cond),
        .out_jump  (out_jump),
        .out_addr  (out_addr)
    );

    always #clk_half clock = ~clock;

    // x^16 + x^15 + x^13 + x^4 + 1 stepped once per bit
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            fb   = lfsr[15] ^ lfsr[14] ^ lfsr[12] ^ lfsr[3];
            lfsr = {lfsr[14:0], fb};
            v    = {v[62:0], fb};
        end
        return v;
    endfunction

    task automatic announce_failure(input string line);
        $display("%s", line);
        $display("*** TEST FAILED ***");
    endtask

    task automatic expect_result(input opcode_t op, input word_t a, input word_t b,
                                 input word_t target, input imm_t value, input logic high);
        word_t d;
        word_t ones;
        logic  c;
        logic  j;
        d    = '0;
        ones = '1;
        c    = 1'b0;
        j    = 1'b0;
        case (op)
            op_add:                   d = a + b;
            op_sub:                   d = a - b;
            op_shl:                   d = (b > 64'd63) ? ones : (a << b) | ~(ones << b);
            op_shr:                   d = (b > 64'd63) ? ones : (a >> b) | ~(ones >> b);
            op_pass, op_call, op_ret: d = a;
            op_load:
            begin
                d = a;
                if (high)
                    d[63:32] = value;
                else
                    d[31:0] = value;
            end
            op_eq:                    c = (a == b);
            op_lt:                    c = (a < b);
            op_gt:                    c = (a > b);
            op_nf1:                   c = !m_f1;
            op_f1f2:                  c = m_f1 && m_f2;
            op_f1:                    c = m_f1;
            op_jmp:                   j = 1'b1;
            op_bf1:                   j = m_f1;
            default:                  d = '0;
        endcase
        if (op == op_eq || op == op_lt || op == op_gt)
        begin
            m_f2 = m_f1;
            m_f1 = c;
        end
        exp_q.push_back({d, c, j, j ? target : 64'h0});
    endtask

    // four-phase send entered and left 1 ns after an edge
    task automatic send_cmd(input opcode_t op, input word_t a, input word_t b);
        in_op     = op;
        in_a      = a;
        in_b      = b;
        in_target = rand_bits(64);
        in_value  = imm_t'(rand_bits(32));
        in_high   = 1'(rand_bits(1));
        expect_result(op, a, b, in_target, in_value, in_high);
        in_req = 1'b1;
        do
        begin
            @(posedge clock);
            #1;
        end
        while (!in_ack);
        in_req = 1'b0;
        do
        begin
            @(posedge clock);
            #1;
        end
        while (in_ack);
        sent++;
    endtask

    task automatic pick_operands(input int cls, output word_t a, output word_t b);
        word_t base;
        word_t gap;
        base = rand_bits(63);  // top bit clear so the sum cannot wrap
        gap  = rand_bits(8) + 64'd1;
        a    = base;
        b    = base;
        if (cls == 1)
            b = base + gap;
        else if (cls == 2)
            a = base + gap;
    endtask

    function automatic opcode_t arith_op(input logic [2:0] sel);
        case (sel)
            3'd0, 3'd7: return op_add;
            3'd1:       return op_sub;
            3'd2:       return op_pass;
            3'd4:       return op_call;
            3'd5:       return op_ret;
            default:    return op_load;
        endcase
    endfunction

    assert property (@(posedge clock) disable iff (!arst_n) $rose(in_ack) |-> $past(in_req))
    else
    begin
        announce_failure("handshake error: in_ack rose while in_req was low");
        $fatal(1, "input handshake");
    end

    assert property (@(posedge clock) disable iff (!arst_n) out_req && !out_ack |=> out_req)
    else
    begin
        announce_failure("handshake error: out_req dropped before out_ack was seen");
        $fatal(1, "output handshake");
    end

    initial
    begin : consumer
        logic [129:0] expected;
        int           stall;
        out_ack = 1'b0;
        forever
        begin
            @(posedge clock);
            #1;
            if (out_req && !out_ack)
            begin
                assert (exp_q.size() > 0)
                else
                begin
                    announce_failure("a result arrived with no command outstanding");
                    $fatal(1, "extra result");
                end
                expected = exp_q.pop_front();
                assert ({out_data, out_cond, out_jump, out_addr} === expected)
                else
                begin
                    announce_failure($sformatf(
                        "[FAIL] %0t: result %0d got %h/%b/%b/%h, expected %h/%b/%b/%h",
                        $time, received, out_data, out_cond, out_jump, out_addr,
                        expected[129:66], expected[65], expected[64], expected[63:0]));
                    $fatal(1, "result mismatch");
                end
                received++;
                stall = int'(rand_bits(3));  // 0 to 7 cycles of back-pressure
                repeat (stall) @(posedge clock);
                #1 out_ack = 1'b1;
                do
                begin
                    @(posedge clock);
                    #1;
                end
                while (out_req);
                out_ack = 1'b0;
            end
        end
    end

    initial
    begin : watchdog
        #((num_cmds * 200 + 20) * 2 * clk_half);
        announce_failure("timeout: the commands did not complete in the allowed time");
        $fatal(1, "watchdog timeout");
    end

    initial
    begin : stimulus
        word_t a;
        word_t b;
        clock     = 1'b0;
        arst_n    = 1'b0;
        in_req    = 1'b0;
        in_op     = '0;
        in_a      = '0;
        in_b      = '0;
        in_target = '0;
        in_value  = '0;
        in_high   = 1'b0;
        lfsr      = 16'd25152;
        m_f1      = 1'b0;
        m_f2      = 1'b0;
        sent      = 0;
        received  = 0;
        repeat (8) @(posedge clock);
        #1 arst_n = 1'b1;
        assert (!in_ack && !out_req && !out_jump)
        else
        begin
            announce_failure("in_ack, out_req or out_jump was high right after reset");
            $fatal(1, "reset state");
        end

        for (int i = 0; i < 24; i++)
            send_cmd(arith_op(3'(rand_bits(3))), rand_bits(64), rand_bits(64));

        for (int amt = 0; amt <= 70; amt++)
        begin
            send_cmd(op_shl, rand_bits(64), word_t'(amt));
            send_cmd(op_shr, rand_bits(64), word_t'(amt));
        end

        // equal, smaller and larger against each compare with a pass in between
        for (int cls = 0; cls < 3; cls++)
            for (int k = 0; k < 3; k++)
            begin
                pick_operands(cls, a, b);
                send_cmd(opcode_t'(8 + k), a, b);
                send_cmd(op_pass, rand_bits(64), rand_bits(64));
                pick_operands((cls + k + 1) % 3, a, b);
                send_cmd(opcode_t'(8 + (k + 1) % 3), a, b);
                send_cmd(op_nf1, rand_bits(64), rand_bits(64));
                send_cmd(op_f1f2, rand_bits(64), rand_bits(64));
                send_cmd(op_f1, rand_bits(64), rand_bits(64));
                send_cmd(op_bf1, rand_bits(64), rand_bits(64));
                send_cmd(op_jmp, rand_bits(64), rand_bits(64));
            end

        wait (received == sent);
        repeat (20) @(posedge clock);  // catch any late extra result
        #1;
        if (out_req)
        begin
            announce_failure("a result was presented after every command had been answered");
            $fatal(1, "extra result");
        end
        else
        begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire
